// File: dv/life_props.sv
`timescale 1ns/100ps

module life_props (
    input logic clk,
    input logic reset_n,
    input logic preset_load,
    input logic step,
    input logic busy,
    input logic load_start,
    input logic eval_start
);

    logic cmd;
    int   fails = 0;

    assign cmd = preset_load | step;

    // Engine idle in the first cycle out of reset
    idle_after_reset: assert property (
        @(posedge clk) $rose(reset_n) |-> !busy
    ) else begin
        fails++;
        $error("busy high in the first cycle after reset");
    end

    // Accepted command raises busy on the next edge
    busy_on_accept: assert property (
        @(posedge clk) disable iff (!reset_n)
        (cmd && !busy) |=> busy
    ) else begin
        fails++;
        $error("busy did not rise after an accepted command");
    end

    // Preset window is one row per cycle
    preset_window: assert property (
        @(posedge clk) disable iff (!reset_n)
        (preset_load && !busy) |=> busy [*30] ##1 !busy
    ) else begin
        fails++;
        $error("preset busy window is not 30 cycles");
    end

    // A pulse while busy starts nothing new
    busy_pulse_ignored: assert property (
        @(posedge clk) disable iff (!reset_n)
        (cmd && busy) |=> !load_start && !eval_start
    ) else begin
        fails++;
        $error("command pulse during busy restarted the engine");
    end

endmodule

bind life_top life_props u_props (
    .clk         (clk),
    .reset_n     (reset_n),
    .preset_load (preset_load),
    .step        (step),
    .busy        (busy),
    .load_start  (load_start),
    .eval_start  (eval_start)
);

// File: dv/life_tb.sv
`timescale 1ns/100ps

module life_tb;
    import life_pkg::*;
    import ctrl_pkg::*;

    logic     clk;
    logic     reset_n;
    logic     preset_load;
    preset_e  preset_sel;
    logic     step;
    logic     busy;
    row_idx_t rd_row;
    row_t     rd_data;

    row_t        model [GRID_ROWS]; // Expected grid contents
    logic [31:0] lfsr;
    int          errors;
    int          checks;

    life_top DUT (
        .clk, .reset_n,
        .preset_load, .preset_sel, .step,
        .busy,
        .rd_row, .rd_data
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic int take_bits(int n);
        logic fb;
        int   val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = (val << 1) | int'(fb);
        end
        return val;
    endfunction

    // Pattern images, bit 39 is the leftmost column
    function automatic row_t table_row(preset_e p, int r);
        row_t d;
        d = '0;
        if (p == PRESET_GLIDER) begin
            if (r == 0) d = 40'h40_0000_0000;
            if (r == 1) d = 40'h30_0000_0000;
            if (r == 2) d = 40'h60_0000_0000;
        end else if (p == PRESET_EXPLODER) begin
            if (r == 13 || r == 17) d = row_t'(5'b10101) << 18;
            if (r >= 14 && r <= 16) d = row_t'(5'b10001) << 18;
        end else if (p == PRESET_TUMBLER) begin
            if (r == 13 || r == 14) d = row_t'(5'b11011) << 18;
            if (r == 15)            d = row_t'(5'b01010) << 18;
            if (r == 16 || r == 17) d = row_t'(7'b1010101) << 17;
            if (r == 18)            d = row_t'(7'b1100011) << 17;
        end
        return d;
    endfunction

    function automatic logic alive(int r, int b);
        if (r < 0 || r >= GRID_ROWS || b < 0 || b >= GRID_COLS)
            return 1'b0; // Outside the border
        return model[r][b];
    endfunction

    task automatic model_step();
        row_t nxt [GRID_ROWS];
        int   n;
        for (int r = 0; r < GRID_ROWS; r++) begin
            for (int b = 0; b < GRID_COLS; b++) begin
                n = 0;
                for (int dr = -1; dr <= 1; dr++)
                    for (int db = -1; db <= 1; db++)
                        if (dr != 0 || db != 0)
                            n += int'(alive(r + dr, b + db));
                nxt[r][b] = (n == 3) || (model[r][b] && n == 2);
            end
        end
        for (int r = 0; r < GRID_ROWS; r++)
            model[r] = nxt[r];
    endtask

    task automatic check_row(int r);
        rd_row = row_idx_t'(r);
        @(posedge clk);
        #2;
        checks++;
        assert (rd_data === model[r]) else begin
            errors++;
            $display("error: rd_data row %0d is %h, expected %h", r, rd_data, model[r]);
        end
    endtask

    // Reads all rows in an LFSR-chosen order
    task automatic check_grid();
        int start;
        start = take_bits(5) % GRID_ROWS;
        assert (!busy) else begin
            errors++;
            $display("busy is high while the grid is being read");
        end
        for (int i = 0; i < GRID_ROWS; i++)
            check_row((start + 7 * i) % GRID_ROWS);
    endtask

    task automatic idle_gap();
        int n;
        n = take_bits(3);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_idle();
        int cyc;
        cyc = 0;
        while (busy && cyc < 200) begin
            @(posedge clk);
            #2;
            cyc++;
        end
        if (busy) begin
            errors++;
            $display("timeout: busy stayed high for 200 cycles");
        end
    endtask

    task automatic pulse_preset(preset_e p);
        preset_load = 1'b1;
        preset_sel  = p;
        @(posedge clk);
        #2;
        preset_load = 1'b0;
    endtask

    task automatic pulse_step();
        step = 1'b1;
        @(posedge clk);
        #2;
        step = 1'b0;
    endtask

    task automatic load_and_check(preset_e p);
        idle_gap();
        pulse_preset(p);
        wait_idle();
        for (int r = 0; r < GRID_ROWS; r++)
            model[r] = table_row(p, r);
        check_grid();
    endtask

    task automatic run_steps(int n);
        for (int i = 0; i < n; i++) begin
            idle_gap();
            pulse_step();
            wait_idle();
            model_step();
            check_grid();
        end
    endtask

    initial begin
        reset_n     = 1'b0;
        preset_load = 1'b0;
        preset_sel  = PRESET_CLEAR;
        step        = 1'b0;
        rd_row      = '0;
        lfsr        = 32'hef8;
        errors      = 0;
        checks      = 0;
        for (int r = 0; r < GRID_ROWS; r++)
            model[r] = '0;

        repeat (4) @(posedge clk);
        #2;
        reset_n = 1'b1;
        check_grid();

        for (int p = 0; p < 4; p++)
            load_and_check(preset_e'(p));

        load_and_check(PRESET_GLIDER);
        run_steps(5); // Glider starts on the top edge and moves away from it
        load_and_check(PRESET_EXPLODER);
        run_steps(4);
        load_and_check(PRESET_TUMBLER);
        run_steps(4);

        // Pulses while busy are dropped
        pulse_step();
        repeat (3) @(posedge clk);
        #2;
        pulse_step();
        pulse_preset(PRESET_GLIDER);
        wait_idle();
        model_step();
        check_grid();
        pulse_preset(PRESET_EXPLODER);
        pulse_step();
        wait_idle();
        for (int r = 0; r < GRID_ROWS; r++)
            model[r] = table_row(PRESET_EXPLODER, r);
        check_grid();

        load_and_check(PRESET_CLEAR);
        run_steps(1);

        $display("checks %0d, errors %0d, property failures %0d",
                 checks, errors, DUT.u_props.fails);
        if (errors == 0 && DUT.u_props.fails == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: logic/ctrl_pkg.sv
package ctrl_pkg;

    // Pattern selected by a preset command
    typedef enum logic [1:0] {
        PRESET_CLEAR,
        PRESET_GLIDER,
        PRESET_EXPLODER,
        PRESET_TUMBLER
    } preset_e;

    // Command sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOAD,   // Pattern rows going into the grid
        SEQ_EVAL,   // Next generation going into the buffer
        SEQ_COMMIT  // Buffer copied back into the grid
    } seq_state_e;

endpackage

// File: logic/grid_writer.sv
`timescale 1ns/100ps

module grid_writer (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               load_start,
    input  ctrl_pkg::preset_e  load_preset,
    input  logic               commit_start,
    output life_pkg::row_idx_t cmt_row,
    input  life_pkg::row_t     cmt_data,
    output logic               wr_en,
    output life_pkg::row_idx_t wr_row,
    output life_pkg::row_t     wr_data,
    output logic               write_done
);
    import life_pkg::*;
    import ctrl_pkg::*;

    logic     load_run, load_wr, cmt_run, cmt_rd, cmt_vld;
    row_idx_t cnt, cmt_wrow;

    // Preset bit images
    function automatic row_t pattern_row(preset_e p, row_idx_t r);
        row_t d;
        d = '0;
        case (p)
            PRESET_GLIDER: begin
                case (r)
                    5'd0: d = {2'b01, {38{1'b0}}};
                    5'd1: d = {2'b00, 2'b11, {36{1'b0}}};
                    5'd2: d = {3'b011, {37{1'b0}}};
                    default: d = '0;
                endcase
            end
            PRESET_EXPLODER: begin
                case (r)
                    5'd13, 5'd17:        d = {{17{1'b0}}, 5'b10101, {18{1'b0}}};
                    5'd14, 5'd15, 5'd16: d = {{17{1'b0}}, 5'b10001, {18{1'b0}}};
                    default: d = '0;
                endcase
            end
            PRESET_TUMBLER: begin
                case (r)
                    5'd13, 5'd14: d = {{17{1'b0}}, 5'b11011, {18{1'b0}}};
                    5'd15:        d = {{17{1'b0}}, 5'b01010, {18{1'b0}}};
                    5'd16, 5'd17: d = {{16{1'b0}}, 7'b1010101, {17{1'b0}}};
                    5'd18:        d = {{16{1'b0}}, 7'b1100011, {17{1'b0}}};
                    default: d = '0;
                endcase
            end
            PRESET_CLEAR: d = '0;
            default:      d = '0;
        endcase
        return d;
    endfunction

    assign load_wr    = load_start | load_run;  // First row goes out with the start pulse
    assign cmt_rd     = commit_start | cmt_run;
    assign cmt_row    = cnt;
    assign wr_en      = load_wr | cmt_vld;
    assign wr_row     = cmt_vld ? cmt_wrow : cnt;
    assign wr_data    = cmt_vld ? cmt_data : pattern_row(load_preset, cnt);
    assign write_done = (load_wr && cnt == LAST_ROW) || (cmt_vld && cmt_wrow == LAST_ROW);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt      <= '0;
            load_run <= 1'b0;
            cmt_run  <= 1'b0;
            cmt_vld  <= 1'b0;
        end else begin
            if (load_wr || cmt_rd)
                cnt <= (cnt == LAST_ROW) ? '0 : cnt + 1'b1;
            load_run <= load_wr && (cnt != LAST_ROW);
            cmt_run  <= cmt_rd && (cnt != LAST_ROW);
            cmt_vld  <= cmt_rd; // Buffer data lands next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (cmt_rd)
            cmt_wrow <= cnt;
    end

endmodule

// File: logic/life_grid.sv
`timescale 1ns/100ps

module life_grid (
    input  logic               clk,
    input  logic               reset_n,
    input  life_pkg::row_idx_t eng_row,
    output life_pkg::row_t     eng_data,
    input  life_pkg::row_idx_t rd_row,
    output life_pkg::row_t     rd_data,
    input  logic               wr_en,
    input  life_pkg::row_idx_t wr_row,
    input  life_pkg::row_t     wr_data
);
    import life_pkg::*;

    row_t cells [GRID_ROWS]; // Current generation

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < GRID_ROWS; r++)
                cells[r] <= '0;
        end else if (wr_en) begin
            cells[wr_row] <= wr_data;
        end
    end

    // Engine and host read ports
    always_ff @(posedge clk) begin
        eng_data <= cells[eng_row];
        rd_data  <= cells[rd_row];
    end

endmodule

// File: logic/life_pkg.sv
package life_pkg;

    // Grid geometry
    localparam int GRID_COLS = 40;
    localparam int GRID_ROWS = 30;

    // One row of cells, bit 39 is the leftmost column
    typedef logic [GRID_COLS-1:0] row_t;

    // Row index into the grid
    typedef logic [4:0] row_idx_t;

    localparam row_idx_t LAST_ROW = row_idx_t'(GRID_ROWS - 1); // Bottom row

endpackage

// File: logic/life_sequencer.sv
`timescale 1ns/100ps

module life_sequencer (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              preset_load,
    input  ctrl_pkg::preset_e preset_sel,
    input  logic              step,
    input  logic              eval_done,
    input  logic              write_done,
    output logic              busy,
    output logic              load_start,
    output logic              commit_start,
    output logic              eval_start,
    output ctrl_pkg::preset_e load_preset
);
    import ctrl_pkg::*;

    seq_state_e state;

    assign busy = (state != SEQ_IDLE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= SEQ_IDLE;
            load_start   <= 1'b0;
            eval_start   <= 1'b0;
            commit_start <= 1'b0;
            load_preset  <= PRESET_CLEAR;
        end else begin
            load_start   <= 1'b0;
            eval_start   <= 1'b0;
            commit_start <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (preset_load) begin // Preset wins over step
                        state       <= SEQ_LOAD;
                        load_start  <= 1'b1;
                        load_preset <= preset_sel;
                    end else if (step) begin
                        state      <= SEQ_EVAL;
                        eval_start <= 1'b1;
                    end
                end
                SEQ_LOAD: begin
                    if (write_done)
                        state <= SEQ_IDLE;
                end
                SEQ_EVAL: begin
                    // All rows computed, copy them back
                    if (eval_done) begin
                        state        <= SEQ_COMMIT;
                        commit_start <= 1'b1;
                    end
                end
                SEQ_COMMIT: begin
                    if (write_done)
                        state <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

// File: logic/life_top.sv
`timescale 1ns/100ps

module life_top (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               preset_load,
    input  ctrl_pkg::preset_e  preset_sel,
    input  logic               step,
    output logic               busy,
    input  life_pkg::row_idx_t rd_row,
    output life_pkg::row_t     rd_data
);
    import life_pkg::*;
    import ctrl_pkg::*;

    logic     load_start, eval_start, commit_start;
    logic     eval_done, write_done;
    preset_e  load_preset;
    row_idx_t eng_row, buf_row, cmt_row, wr_row;
    row_t     eng_data, buf_data, cmt_data, wr_data;
    logic     buf_wr, wr_en;

    life_sequencer u_seq (
        .clk, .reset_n,
        .preset_load, .preset_sel, .step,
        .eval_done, .write_done,
        .busy,
        .load_start, .commit_start, .eval_start,
        .load_preset
    );

    life_grid u_grid (
        .clk, .reset_n,
        .eng_row, .eng_data,
        .rd_row, .rd_data,
        .wr_en, .wr_row, .wr_data
    );

    row_evaluator u_eval (
        .clk, .reset_n,
        .eval_start,
        .eng_row, .eng_data,
        .buf_wr, .buf_row, .buf_data,
        .eval_done
    );

    next_gen_buffer u_buf (
        .clk,
        .buf_wr, .buf_row, .buf_data,
        .cmt_row, .cmt_data
    );

    grid_writer u_writer (
        .clk, .reset_n,
        .load_start, .load_preset,
        .commit_start,
        .cmt_row, .cmt_data,
        .wr_en, .wr_row, .wr_data,
        .write_done
    );

endmodule

// File: logic/next_gen_buffer.sv
`timescale 1ns/100ps

module next_gen_buffer (
    input  logic               clk,
    input  logic               buf_wr,
    input  life_pkg::row_idx_t buf_row,
    input  life_pkg::row_t     buf_data,
    input  life_pkg::row_idx_t cmt_row,
    output life_pkg::row_t     cmt_data
);
    import life_pkg::*;

    // Next generation, held until every row has seen the old one
    row_t mem [GRID_ROWS];

    always_ff @(posedge clk) begin
        if (buf_wr)
            mem[buf_row] <= buf_data;
    end

    always_ff @(posedge clk) begin
        cmt_data <= mem[cmt_row]; // Registered read
    end

endmodule

// File: logic/row_evaluator.sv
`timescale 1ns/100ps

module row_evaluator (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               eval_start,
    output life_pkg::row_idx_t eng_row,
    input  life_pkg::row_t     eng_data,
    output logic               buf_wr,
    output life_pkg::row_idx_t buf_row,
    output life_pkg::row_t     buf_data,
    output logic               eval_done
);
    import life_pkg::*;

    logic     rd_run, rd_go, arr_vld, arr_last, flush, shift, calc_vld;
    row_idx_t rd_cnt, shift_cnt, calc_row;
    row_t     win_up, win_mid, win_dn;

    // Next state of the centre row, cells past the edges are dead
    function automatic row_t next_row(row_t up, row_t mid, row_t dn);
        row_t       nxt;
        row_t       up_l, up_r, mid_l, mid_r, dn_l, dn_r;
        logic [3:0] n;
        up_l  = up >> 1;
        up_r  = up << 1;
        mid_l = mid >> 1;
        mid_r = mid << 1;
        dn_l  = dn >> 1;
        dn_r  = dn << 1;
        for (int c = 0; c < GRID_COLS; c++) begin
            n = 4'(up_l[c]) + 4'(up[c]) + 4'(up_r[c]) + 4'(mid_l[c]) + 4'(mid_r[c])
              + 4'(dn_l[c]) + 4'(dn[c]) + 4'(dn_r[c]);
            nxt[c] = (n == 4'd3) || (mid[c] && n == 4'd2); // Birth or survival
        end
        return nxt;
    endfunction

    assign rd_go     = eval_start | rd_run;
    assign eng_row   = rd_cnt;
    assign shift     = arr_vld | flush;
    assign eval_done = buf_wr && (buf_row == LAST_ROW);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_run    <= 1'b0;
            rd_cnt    <= '0;
            arr_vld   <= 1'b0;
            arr_last  <= 1'b0;
            flush     <= 1'b0;
            shift_cnt <= '0;
            calc_vld  <= 1'b0;
            buf_wr    <= 1'b0;
        end else begin
            if (rd_go)
                rd_cnt <= (rd_cnt == LAST_ROW) ? '0 : rd_cnt + 1'b1;
            rd_run   <= rd_go && (rd_cnt != LAST_ROW);
            arr_vld  <= rd_go;                          // Grid read has one cycle latency
            arr_last <= rd_go && (rd_cnt == LAST_ROW);
            flush    <= arr_vld && arr_last;            // Dead row below row 29
            if (eval_start)
                shift_cnt <= '0;
            else if (shift)
                shift_cnt <= shift_cnt + 1'b1;
            calc_vld <= shift && (shift_cnt != '0);     // Centre valid from second shift on
            buf_wr   <= calc_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (eval_start) begin
            win_up  <= '0; // Row above row 0 is dead
            win_mid <= '0;
            win_dn  <= '0;
        end else if (shift) begin
            win_up  <= win_mid;
            win_mid <= win_dn;
            win_dn  <= flush ? '0 : eng_data;
        end
        if (shift)
            calc_row <= shift_cnt - 1'b1;
        if (calc_vld) begin
            buf_row  <= calc_row;
            buf_data <= next_row(win_up, win_mid, win_dn);
        end
    end

endmodule

// File: project.f
logic/life_pkg.sv
logic/ctrl_pkg.sv
logic/life_sequencer.sv
logic/life_grid.sv
logic/row_evaluator.sv
logic/next_gen_buffer.sv
logic/grid_writer.sv
logic/life_top.sv
dv/life_props.sv
dv/life_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the Life engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module life_tb -o life_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/life_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation passed" sim.log || exit 1
exit 0
